//--- rtl/lcg_cfg.svh
// Generator constants and bus widths shared by the RTL and the testbench, pulled in by `include
`ifndef LCG_CFG_SVH
`define LCG_CFG_SVH

// ======================================================================
// Generator constants
// ======================================================================

// Multiplier A of x <= A*x + C
`define LCG_MULT        32'h41C64E6D

// Increment C
`define LCG_INC         32'h00003039

// State loaded by ARESETN
`define LCG_RESET_SEED  32'h12345678

// ======================================================================
// AXI4-Lite port widths
// ======================================================================

`define AXIL_ADDR_W     4
`define AXIL_DATA_W     32

`endif

//--- rtl/axil_pkg.sv
// AXI4-Lite response encodings, imported by the slave and the testbench
`default_nettype none

package axil_pkg;

    // Two-bit BRESP / RRESP field
    typedef logic [1:0] axil_resp_t;

    // Normal completion
    localparam axil_resp_t RESP_OKAY   = 2'b00;

    // Slave error, used for bad addresses and illegal accesses
    localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- rtl/lcg_pkg.sv
// Register map of the random number generator, imported by the slave and the testbench
`default_nettype none

`include "lcg_cfg.svh"

package lcg_pkg;

    // Byte addresses on the 4-bit AXI4-Lite space
    typedef enum logic [`AXIL_ADDR_W-1:0] {
        // Read only, current generator value
        REG_RAND = 'h0,
        // Bit 0 enables stepping on RAND reads
        REG_EN   = 'h4,
        // Write only, byte-strobed seed
        REG_SEED = 'h8
    } lcg_reg_t;

endpackage

`default_nettype wire

//--- rtl/lcg_core.sv
// LCG state register with a three-stage multiply-add step and direct seed load
`default_nettype none
`timescale 1ns/1ns

`include "lcg_cfg.svh"

module lcg_core (
    input  logic                    ACLK,
    input  logic                    ARESETN,
    input  logic                    step,
    input  logic                    seed_load,
    input  logic [`AXIL_DATA_W-1:0] seed_value,
    output logic [`AXIL_DATA_W-1:0] state,
    output logic                    ready
);

    localparam int DW = `AXIL_DATA_W;

    localparam logic [DW-1:0] MULT = `LCG_MULT;
    localparam logic [DW-1:0] INC  = `LCG_INC;
    localparam logic [DW-1:0] SEED = `LCG_RESET_SEED;

    // Stage 1, truncated product A*x
    logic [DW-1:0] mult_q;
    // Stage 2, low product word held for the adder
    logic [DW-1:0] prod_lo_q;

    logic          mult_vld;
    logic          lo_vld;

    // ======================================================================
    // Step pipeline payload
    // ======================================================================

    // Mod 2^32, so only the low word of the product is kept
    always_ff @(posedge ACLK) begin
        if (step) begin
            mult_q <= state * MULT;
        end
        if (mult_vld) begin
            prod_lo_q <= mult_q;
        end
    end

    // ======================================================================
    // State and in-flight tracking
    // ======================================================================

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            state    <= SEED;
            mult_vld <= 1'b0;
            lo_vld   <= 1'b0;
        end else if (seed_load) begin
            // New seed wins over a step still in flight
            state    <= seed_value;
            mult_vld <= 1'b0;
            lo_vld   <= 1'b0;
        end else begin
            mult_vld <= step;
            lo_vld   <= mult_vld;
            // Stage 3, add C and write back
            if (lo_vld) begin
                state <= prod_lo_q + INC;
            end
        end
    end

    // Low for the two cycles a step is in flight
    assign ready = ~(mult_vld | lo_vld);

endmodule

`default_nettype wire

//--- rtl/axil_rng_regs.sv
// AXI4-Lite slave with the RAND, EN and SEED registers; drives step and seed load of the core
`default_nettype none
`timescale 1ns/1ns

`include "lcg_cfg.svh"

module axil_rng_regs (
    input  logic                        ACLK,
    input  logic                        ARESETN,
    // Write address channel
    input  logic [`AXIL_ADDR_W-1:0]     awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    // Write data channel
    input  logic [`AXIL_DATA_W-1:0]     wdata,
    input  logic [`AXIL_DATA_W/8-1:0]   wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    // Write response channel
    output axil_pkg::axil_resp_t        bresp,
    output logic                        bvalid,
    input  logic                        bready,
    // Read address channel
    input  logic [`AXIL_ADDR_W-1:0]     araddr,
    input  logic                        arvalid,
    output logic                        arready,
    // Read data channel
    output logic [`AXIL_DATA_W-1:0]     rdata,
    output axil_pkg::axil_resp_t        rresp,
    output logic                        rvalid,
    input  logic                        rready,
    // Core side
    output logic                        step,
    output logic                        seed_load,
    output logic [`AXIL_DATA_W-1:0]     seed_value,
    input  logic [`AXIL_DATA_W-1:0]     state,
    input  logic                        ready
);

    import axil_pkg::*;
    import lcg_pkg::*;

    localparam int DW = `AXIL_DATA_W;
    localparam int SW = `AXIL_DATA_W / 8;

    logic          en_q;

    logic          wr_start;
    logic          wr_fire;
    axil_resp_t    wr_resp;

    logic          rd_is_rand;
    logic          rd_start;
    logic          rd_fire;
    logic [DW-1:0] rd_data;
    axil_resp_t    rd_resp;

    // Replace the strobed bytes of old_v with those of new_v
    function automatic logic [DW-1:0] merge_bytes(
        input logic [DW-1:0] old_v,
        input logic [DW-1:0] new_v,
        input logic [SW-1:0] strb
    );
        logic [DW-1:0] res;
        res = old_v;
        for (int i = 0; i < SW; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    // ======================================================================
    // Write path
    // ======================================================================

    // Both channels present and no response outstanding
    assign wr_start = awvalid && wvalid && !awready && !bvalid;
    assign wr_fire  = awvalid && awready && wvalid && wready;

    always_comb begin
        case (awaddr)
            REG_EN,
            REG_SEED: wr_resp = RESP_OKAY;
            // RAND is read only; everything else is unmapped
            default:  wr_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            en_q    <= 1'b0;
        end else begin
            // One-cycle pulse, shared by AW and W
            awready <= wr_start;
            wready  <= wr_start;

            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (wr_fire && (awaddr == REG_EN) && wstrb[0]) begin
                en_q <= wdata[0];
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (wr_fire) begin
            bresp <= wr_resp;
        end
    end

    // Seed goes to the core on the accepting edge
    assign seed_load  = wr_fire && (awaddr == REG_SEED);
    assign seed_value = merge_bytes(state, wdata, wstrb);

    // ======================================================================
    // Read path
    // ======================================================================

    assign rd_is_rand = (araddr == REG_RAND);

    // RAND reads wait for the core to finish any step in flight
    assign rd_start = arvalid && !arready && !rvalid && (!rd_is_rand || ready);
    assign rd_fire  = arvalid && arready;

    // Each enabled RAND read consumes one number
    assign step = rd_fire && rd_is_rand && en_q;

    always_comb begin
        case (araddr)
            REG_RAND: begin
                rd_data = state;
                rd_resp = RESP_OKAY;
            end
            REG_EN: begin
                rd_data = {{(DW-1){1'b0}}, en_q};
                rd_resp = RESP_OKAY;
            end
            // SEED is write only
            default: begin
                rd_data = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= rd_start;

            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Data held until the master takes it
    always_ff @(posedge ACLK) begin
        if (rd_fire) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lcg_rng_axil.sv
// Top level of the AXI4-Lite random number generator; joins the register slave and the LCG core
`default_nettype none
`timescale 1ns/1ns

`include "lcg_cfg.svh"

module lcg_rng_axil (
    input  logic                        ACLK,
    input  logic                        ARESETN,
    input  logic [`AXIL_ADDR_W-1:0]     awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`AXIL_DATA_W-1:0]     wdata,
    input  logic [`AXIL_DATA_W/8-1:0]   wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output axil_pkg::axil_resp_t        bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`AXIL_ADDR_W-1:0]     araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`AXIL_DATA_W-1:0]     rdata,
    output axil_pkg::axil_resp_t        rresp,
    output logic                        rvalid,
    input  logic                        rready
);

    // Slave to core strobes
    logic                    step;
    logic                    seed_load;
    logic [`AXIL_DATA_W-1:0] seed_value;
    // Core back to slave
    logic [`AXIL_DATA_W-1:0] state;
    logic                    core_ready;

    axil_rng_regs u_regs (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .step       (step),
        .seed_load  (seed_load),
        .seed_value (seed_value),
        .state      (state),
        .ready      (core_ready)
    );

    lcg_core u_core (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .step       (step),
        .seed_load  (seed_load),
        .seed_value (seed_value),
        .state      (state),
        .ready      (core_ready)
    );

endmodule

`default_nettype wire

//--- tb/lcg_rng_assert.sv
// AXI4-Lite handshake and core step checks, bound into the register slave by the testbench
`default_nettype none
`timescale 1ns/1ns

`include "lcg_cfg.svh"

module lcg_rng_assert (
    input logic                    ACLK,
    input logic                    ARESETN,
    input logic                    bvalid,
    input logic                    bready,
    input axil_pkg::axil_resp_t    bresp,
    input logic                    rvalid,
    input logic                    rready,
    input logic [`AXIL_DATA_W-1:0] rdata,
    input axil_pkg::axil_resp_t    rresp,
    input logic                    step,
    input logic                    ready
);

    // ======================================================================
    // Channel rules
    // ======================================================================

    // Stalled write response holds
    a_b_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response changed while stalled");

    a_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("read data changed while stalled");

    // No new step while one is in flight
    a_step_ready: assert property (@(posedge ACLK) disable iff (!ARESETN)
        step |-> ready)
        else $error("step pulsed while core busy");

endmodule

`default_nettype wire

//--- tb/tb_lcg_rng_axil.sv
// Testbench for the AXI4-Lite LCG generator; runs a table of bus operations against an LCG model
`default_nettype none
`timescale 1ns/1ns

`include "lcg_cfg.svh"

module tb_lcg_rng_axil;

    import axil_pkg::*;
    import lcg_pkg::*;

    localparam int AW         = `AXIL_ADDR_W;
    localparam int DW         = `AXIL_DATA_W;
    localparam int SW         = `AXIL_DATA_W / 8;
    localparam int WAIT_LIMIT = 50;
    localparam bit OP_RD      = 1'b0;
    localparam bit OP_WR      = 1'b1;

    // One bus operation and what it should return
    typedef struct packed {
        logic          is_write;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic [SW-1:0] strb;
        axil_resp_t    resp;
        logic          use_model;
        logic [DW-1:0] exp_data;
    } row_t;

    logic          ACLK;
    logic          ARESETN;
    logic [AW-1:0] awaddr;
    logic          awvalid;
    logic          awready;
    logic [DW-1:0] wdata;
    logic [SW-1:0] wstrb;
    logic          wvalid;
    logic          wready;
    axil_resp_t    bresp;
    logic          bvalid;
    logic          bready;
    logic [AW-1:0] araddr;
    logic          arvalid;
    logic          arready;
    logic [DW-1:0] rdata;
    axil_resp_t    rresp;
    logic          rvalid;
    logic          rready;

    row_t          rows[$];
    logic [DW-1:0] model_x;
    logic          model_en;

    lcg_rng_axil u_dut (.*);

    bind axil_rng_regs lcg_rng_assert u_assert (
        .ACLK    (ACLK),
        .ARESETN (ARESETN),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .step    (step),
        .ready   (ready)
    );

    initial begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    // ======================================================================
    // Reporting and reference model
    // ======================================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    function automatic logic [DW-1:0] lcg_next(input logic [DW-1:0] x);
        return x * `LCG_MULT + `LCG_INC;
    endfunction

    // Byte lanes with the strobe set come from new_v
    function automatic logic [DW-1:0] strobe_merge(input logic [DW-1:0] old_v,
                                                   input logic [DW-1:0] new_v,
                                                   input logic [SW-1:0] strb);
        logic [DW-1:0] mask;
        mask = '0;
        for (int b = 0; b < SW; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    // ======================================================================
    // Bus tasks
    // ======================================================================

    task automatic write_reg(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                             input logic [SW-1:0] strb, output axil_resp_t resp);
        int          cnt;
        int unsigned stall;
        @(negedge ACLK);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        cnt = 0;
        while (!(awready && wready)) begin
            cnt++;
            if (cnt > WAIT_LIMIT) abort_run("write address and data were never accepted");
            @(negedge ACLK);
        end
        @(negedge ACLK);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cnt = 0;
        while (!bvalid) begin
            cnt++;
            if (cnt > WAIT_LIMIT) abort_run("write response never arrived");
            @(negedge ACLK);
        end
        // Random back-pressure on B
        stall = $urandom_range(4, 0);
        repeat (stall) @(negedge ACLK);
        resp   = bresp;
        bready = 1'b1;
        @(negedge ACLK);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                            output axil_resp_t resp);
        int          cnt;
        int unsigned stall;
        @(negedge ACLK);
        araddr  = addr;
        arvalid = 1'b1;
        cnt = 0;
        while (!arready) begin
            cnt++;
            if (cnt > WAIT_LIMIT) abort_run("read address was never accepted");
            @(negedge ACLK);
        end
        @(negedge ACLK);
        arvalid = 1'b0;
        cnt = 0;
        while (!rvalid) begin
            cnt++;
            if (cnt > WAIT_LIMIT) abort_run("read data never arrived");
            @(negedge ACLK);
        end
        stall = $urandom_range(4, 0);
        repeat (stall) @(negedge ACLK);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge ACLK);
        rready = 1'b0;
    endtask

    task automatic add_row(input logic is_wr, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data, input logic [SW-1:0] strb,
                           input axil_resp_t resp, input logic use_model,
                           input logic [DW-1:0] exp_data);
        rows.push_back('{is_wr, addr, data, strb, resp, use_model, exp_data});
    endtask

    // ======================================================================
    // Stimulus table
    // ======================================================================

    task automatic build_table();
        // Enable off, state must not move
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b0, `LCG_RESET_SEED);
        add_row(OP_RD, REG_EN, '0, '0, RESP_OKAY, 1'b0, '0);
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        // Enable on, each read consumes one number
        add_row(OP_WR, REG_EN, 32'h1, 4'hF, RESP_OKAY, 1'b0, '0);
        add_row(OP_RD, REG_EN, '0, '0, RESP_OKAY, 1'b0, 32'h1);
        for (int i = 0; i < 5; i++) begin
            add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        end
        // Full and partial seed writes
        add_row(OP_WR, REG_SEED, 32'hCAFEBABE, 4'hF, RESP_OKAY, 1'b0, '0);
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b0, 32'hCAFEBABE);
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        add_row(OP_WR, REG_SEED, 32'h11223344, 4'b0101, RESP_OKAY, 1'b0, '0);
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        // Illegal accesses
        add_row(OP_WR, REG_RAND, 32'hDEADBEEF, 4'hF, RESP_SLVERR, 1'b0, '0);
        add_row(OP_WR, 4'hC, 32'h0BAD0BAD, 4'hF, RESP_SLVERR, 1'b0, '0);
        add_row(OP_WR, 4'h2, 32'h12121212, 4'hF, RESP_SLVERR, 1'b0, '0);
        add_row(OP_RD, REG_SEED, '0, '0, RESP_SLVERR, 1'b0, '0);
        add_row(OP_RD, 4'hC, '0, '0, RESP_SLVERR, 1'b0, '0);
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        // Disable, then an EN write without lane 0
        add_row(OP_WR, REG_EN, 32'h0, 4'hF, RESP_OKAY, 1'b0, '0);
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        add_row(OP_WR, REG_EN, 32'hFFFFFFFF, 4'b1110, RESP_OKAY, 1'b0, '0);
        add_row(OP_RD, REG_EN, '0, '0, RESP_OKAY, 1'b0, 32'h0);
        add_row(OP_WR, REG_EN, 32'h1, 4'b0001, RESP_OKAY, 1'b0, '0);
        for (int i = 0; i < 3; i++) begin
            add_row(OP_RD, REG_RAND, '0, '0, RESP_OKAY, 1'b1, '0);
        end
    endtask

    initial begin
        row_t          row;
        logic [DW-1:0] got_data;
        logic [DW-1:0] exp_v;
        axil_resp_t    got_resp;
        void'($urandom(32'h1a47));
        ARESETN  = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        model_x  = `LCG_RESET_SEED;
        model_en = 1'b0;
        build_table();
        repeat (8) @(posedge ACLK);
        @(negedge ACLK);
        ARESETN = 1'b1;
        check_value("awready", 32'(awready), '0);
        check_value("arready", 32'(arready), '0);
        check_value("bvalid", 32'(bvalid), '0);
        check_value("rvalid", 32'(rvalid), '0);

        foreach (rows[i]) begin
            row = rows[i];
            if (row.is_write) begin
                write_reg(row.addr, row.data, row.strb, got_resp);
                check_value("bresp", 32'(got_resp), 32'(row.resp));
                if (row.addr == REG_EN && row.strb[0]) model_en = row.data[0];
                if (row.addr == REG_SEED) model_x = strobe_merge(model_x, row.data, row.strb);
            end else begin
                read_reg(row.addr, got_data, got_resp);
                check_value("rresp", 32'(got_resp), 32'(row.resp));
                exp_v = row.use_model ? model_x : row.exp_data;
                check_value("rdata", got_data, exp_v);
                // Read returns the current value, then the generator moves on
                if (row.addr == REG_RAND && model_en) model_x = lcg_next(model_x);
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/axil_pkg.sv
rtl/lcg_pkg.sv
rtl/lcg_core.sv
rtl/axil_rng_regs.sv
rtl/lcg_rng_axil.sv
tb/lcg_rng_assert.sv
tb/tb_lcg_rng_axil.sv

//--- Makefile
TOP := tb_lcg_rng_axil

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || echo "Test FAILED" >> sim.log
	cat sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
